// ==== mips_exe_pkg.sv ====
package mips_exe_pkg;

    typedef logic [31:0] word_t;   // data word or address
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  func_t;
    typedef logic [4:0]  shamt_t;  // also picks mul low/high word
    typedef logic [25:0] jidx_t;

    // decoded instruction with operands already read
    typedef struct packed {
        word_t   reg1;          // rs
        word_t   reg2;          // rt
        word_t   immd;          // extended by the decoder
        word_t   next_pc;
        logic    alu_src;       // 0 reg2, 1 immd
        opcode_t opcode;
        func_t   func;
        shamt_t  ins_shamt;
        logic    r_op;
        jidx_t   ins_j_addr;
        logic    is_jump;
        logic    is_branch;
        logic    is_jal;
        logic    is_jr;
        logic    is_load_store;
        logic    alu_bypass;
        word_t   bypass_immd;
    } id_ex_t;

    typedef struct packed {
        logic  valid;
        word_t result;
        logic  do_jump;
        word_t j_addr;
    } ex_mem_t;

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_BUSY,
        MUL_DONE
    } mul_state_e;

    // primary opcodes
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_J       = 6'b000010;
    localparam opcode_t OP_JAL     = 6'b000011;
    localparam opcode_t OP_BEQ     = 6'b000100;
    localparam opcode_t OP_BNE     = 6'b000101;
    localparam opcode_t OP_BLEZ    = 6'b000110;
    localparam opcode_t OP_BGTZ    = 6'b000111;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_LUI     = 6'b001111;

    // R-type function codes
    localparam func_t FN_SLL  = 6'b000000;
    localparam func_t FN_SRL  = 6'b000010;
    localparam func_t FN_SRA  = 6'b000011;
    localparam func_t FN_SLLV = 6'b000100;
    localparam func_t FN_SRLV = 6'b000110;
    localparam func_t FN_SRAV = 6'b000111;
    localparam func_t FN_JR   = 6'b001000;
    localparam func_t FN_JALR = 6'b001001;
    localparam func_t FN_MUL  = 6'b011000;  // mul / muh, signed
    localparam func_t FN_MULU = 6'b011001;  // mulu / muhu
    localparam func_t FN_SLT  = 6'b101010;
    localparam func_t FN_SLTU = 6'b101011;

    // shamt field of the multiply group
    localparam shamt_t SHAMT_MUL_LO = 5'd2;
    localparam shamt_t SHAMT_MUL_HI = 5'd3;

endpackage

// ==== alu.sv ====
`timescale 1ns/10ps

module alu (
    input  mips_exe_pkg::word_t  reg1,
    input  mips_exe_pkg::word_t  op2,
    input  mips_exe_pkg::word_t  reg2,
    input  mips_exe_pkg::word_t  immd,
    input  logic [2:0]           alu_op,
    input  logic                 is_lui,
    input  logic                 slt_unsigned,
    input  logic [1:0]           shift_sel,
    input  mips_exe_pkg::shamt_t shamt,
    output mips_exe_pkg::word_t  alu_result,
    output logic                 slt_bit,
    output mips_exe_pkg::word_t  shift_out
);
    import mips_exe_pkg::*;

    word_t       op2_n;
    logic        sub;
    logic [32:0] sum;      // bit 32 is the carry out
    logic        cf;
    logic        sf;
    logic        of;

    assign sub   = alu_op[1];  // 01x subtracts
    assign op2_n = ~op2;

    // two's complement subtract keeps a true carry, so op2 == 0 gives cf = 1
    assign sum = sub ? {1'b0, reg1} + {1'b0, op2_n} + 33'd1
                     : {1'b0, reg1} + {1'b0, op2};

    assign cf = sum[32];
    assign sf = sum[31];

    // signed overflow, operand signs vs result sign
    always_comb begin
        if (sub) begin
            of = (reg1[31] ^ op2[31]) & (sum[31] ^ reg1[31]);
        end else begin
            of = ~(reg1[31] ^ op2[31]) & (sum[31] ^ reg1[31]);
        end
    end

    // only meaningful for the subtract ops
    assign slt_bit = slt_unsigned ? ~cf : (of ^ sf);

    always_comb begin
        case (alu_op)
            3'b000,
            3'b001,
            3'b010,
            3'b011: alu_result = sum[31:0];
            3'b100: alu_result = reg1 & op2;
            3'b101: alu_result = reg1 | op2;
            3'b110: alu_result = reg1 ^ op2;
            default: begin
                if (is_lui) begin
                    alu_result = {immd[15:0], 16'h0000};
                end else begin
                    alu_result = ~(reg1 | op2);  // nor
                end
            end
        endcase
    end

    // barrel shifter on rt
    always_comb begin
        case (shift_sel)
            2'b00:   shift_out = reg2 << shamt;
            2'b10:   shift_out = reg2 >> shamt;
            2'b11:   shift_out = word_t'($signed(reg2) >>> shamt);
            default: shift_out = '0;  // undefined encoding
        endcase
    end

endmodule

// ==== branch_unit.sv ====
`timescale 1ns/10ps

module branch_unit (
    input  mips_exe_pkg::word_t   reg1,
    input  mips_exe_pkg::word_t   reg2,
    input  mips_exe_pkg::word_t   immd,
    input  mips_exe_pkg::word_t   next_pc,
    input  mips_exe_pkg::opcode_t opcode,
    input  mips_exe_pkg::jidx_t   ins_j_addr,
    input  logic                  is_jump,
    input  logic                  is_jr,
    input  logic                  is_branch,
    output logic                  do_jump,
    output mips_exe_pkg::word_t   j_addr
);
    import mips_exe_pkg::*;

    logic  taken;
    word_t jump_target;
    word_t branch_target;

    // branch comparator, signed compares against zero
    always_comb begin
        case (opcode)
            OP_BEQ:  taken = reg1 == reg2;
            OP_BNE:  taken = reg1 != reg2;
            OP_BLEZ: taken = reg1[31] || (reg1 == '0);
            OP_BGTZ: taken = !reg1[31] && (reg1 != '0);
            default: taken = 1'b0;
        endcase
    end

    assign jump_target   = {next_pc[31:28], ins_j_addr, 2'b00};
    assign branch_target = next_pc + {immd[29:0], 2'b00};  // word offset

    always_comb begin
        if (is_jump) begin
            do_jump = 1'b1;
            j_addr  = is_jr ? reg1 : jump_target;
        end else if (is_branch && taken) begin
            do_jump = 1'b1;
            j_addr  = branch_target;
        end else begin
            do_jump = 1'b0;
            j_addr  = '0;
        end
    end

endmodule

// ==== multiplier.sv ====
`timescale 1ns/10ps

module multiplier #(
    parameter int MUL_BITS_PER_CYCLE = 2
) (
    input  logic                sys_clk,
    input  logic                arst_n,
    input  logic                start,
    input  logic                is_signed,
    input  mips_exe_pkg::word_t a,
    input  mips_exe_pkg::word_t b,
    output logic                busy,
    output logic                done,
    output logic [63:0]         product
);
    import mips_exe_pkg::*;

    localparam int STEPS = 32 / MUL_BITS_PER_CYCLE;
    localparam int CNT_W = $clog2(STEPS);

    mul_state_e       state;
    logic [CNT_W-1:0] cnt;       // steps left minus one
    logic [63:0]      acc;
    logic [63:0]      mcand;
    word_t            mplier;
    logic             negate;
    logic [63:0]      acc_next;
    word_t            mag_a;
    word_t            mag_b;

    // operand magnitudes, 0x80000000 stays correct as unsigned
    assign mag_a = (is_signed && a[31]) ? -a : a;
    assign mag_b = (is_signed && b[31]) ? -b : b;

    // one radix 2^k digit per cycle
    always_comb begin
        acc_next = acc;
        for (int i = 0; i < MUL_BITS_PER_CYCLE; i++) begin
            if (mplier[i]) begin
                acc_next = acc_next + (mcand << i);
            end
        end
    end

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= MUL_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                MUL_IDLE: begin
                    if (start) begin
                        state <= MUL_BUSY;
                        cnt   <= CNT_W'(STEPS - 1);
                    end
                end
                MUL_BUSY: begin
                    if (cnt == '0) begin
                        state <= MUL_DONE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= MUL_IDLE;  // done is a single cycle
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == MUL_IDLE && start) begin
            acc    <= '0;
            mcand  <= {32'h0, mag_a};
            mplier <= mag_b;
            negate <= is_signed && (a[31] ^ b[31]);
        end else if (state == MUL_BUSY) begin
            acc    <= acc_next;
            mcand  <= mcand << MUL_BITS_PER_CYCLE;
            mplier <= mplier >> MUL_BITS_PER_CYCLE;
            if (cnt == '0) begin
                product <= negate ? -acc_next : acc_next;  // held through MUL_DONE
            end
        end
    end

    assign busy = state == MUL_BUSY;
    assign done = state == MUL_DONE;

endmodule

// ==== execute.sv ====
`timescale 1ns/10ps

module execute #(
    parameter int MUL_BITS_PER_CYCLE = 2
) (
    input  logic                  sys_clk,
    input  logic                  arst_n,
    input  mips_exe_pkg::id_ex_t  id_ex,
    input  logic                  in_valid,
    output mips_exe_pkg::ex_mem_t ex_out,
    output logic                  stall
);
    import mips_exe_pkg::*;

    logic        is_set;
    logic        is_shift;
    logic        is_def;
    logic        is_lui;
    logic        is_mul;
    logic [2:0]  alu_op;
    logic        slt_unsigned;
    word_t       op2;
    shamt_t      shamt;
    word_t       alu_result;
    logic        slt_bit;
    word_t       shift_out;
    logic        do_jump;
    word_t       j_addr;
    logic        mul_start;
    logic        mul_busy;
    logic        mul_done;
    logic [63:0] mul_product;
    word_t       mul_word;
    word_t       result;

    // operation class
    assign is_set = (id_ex.opcode[5:1] == OP_SLTI[5:1])
                 || (id_ex.r_op && id_ex.func[5:1] == FN_SLT[5:1]);
    assign is_shift = id_ex.r_op && id_ex.func[5:3] == FN_SLL[5:3];
    assign is_def = id_ex.opcode[5:3] == 3'b001
                 || (id_ex.r_op && id_ex.func[5:3] == 3'b100)
                 || id_ex.is_load_store;
    assign is_lui = id_ex.opcode == OP_LUI;
    assign is_mul = id_ex.r_op && id_ex.func[5:1] == FN_MUL[5:1];

    // load/store address goes through addu
    always_comb begin
        if (id_ex.is_load_store) begin
            alu_op = 3'b001;
        end else if (id_ex.r_op) begin
            alu_op = id_ex.func[2:0];
        end else begin
            alu_op = id_ex.opcode[2:0];
        end
    end

    assign slt_unsigned = id_ex.r_op ? id_ex.func[0] : id_ex.opcode[0];
    assign op2          = id_ex.alu_src ? id_ex.immd : id_ex.reg2;
    assign shamt        = id_ex.func[2] ? id_ex.reg1[4:0] : id_ex.ins_shamt;  // sllv/srlv/srav

    alu u_alu (
        .reg1         (id_ex.reg1),
        .op2          (op2),
        .reg2         (id_ex.reg2),
        .immd         (id_ex.immd),
        .alu_op       (alu_op),
        .is_lui       (is_lui),
        .slt_unsigned (slt_unsigned),
        .shift_sel    (id_ex.func[1:0]),
        .shamt        (shamt),
        .alu_result   (alu_result),
        .slt_bit      (slt_bit),
        .shift_out    (shift_out)
    );

    branch_unit u_branch_unit (
        .reg1       (id_ex.reg1),
        .reg2       (id_ex.reg2),
        .immd       (id_ex.immd),
        .next_pc    (id_ex.next_pc),
        .opcode     (id_ex.opcode),
        .ins_j_addr (id_ex.ins_j_addr),
        .is_jump    (id_ex.is_jump),
        .is_jr      (id_ex.is_jr),
        .is_branch  (id_ex.is_branch),
        .do_jump    (do_jump),
        .j_addr     (j_addr)
    );

    // start only from idle
    assign mul_start = in_valid && is_mul && !mul_busy && !mul_done;

    multiplier #(
        .MUL_BITS_PER_CYCLE (MUL_BITS_PER_CYCLE)
    ) u_multiplier (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .start     (mul_start),
        .is_signed (!id_ex.func[0]),
        .a         (id_ex.reg1),
        .b         (id_ex.reg2),
        .busy      (mul_busy),
        .done      (mul_done),
        .product   (mul_product)
    );

    assign mul_word = (id_ex.ins_shamt == SHAMT_MUL_LO) ? mul_product[31:0] : mul_product[63:32];
    assign stall    = in_valid && is_mul && !mul_done;  // hold until the product is ready

    // result select in priority order
    always_comb begin
        if (id_ex.alu_bypass) begin
            result = id_ex.bypass_immd;
        end else if (is_set) begin
            result = {31'b0, slt_bit};
        end else if (is_mul) begin
            result = mul_word;
        end else if (is_def) begin
            result = alu_result;
        end else if (is_shift) begin
            result = shift_out;
        end else if (id_ex.is_branch) begin
            result = '0;
        end else if (id_ex.is_jal) begin
            result = id_ex.next_pc + 32'd4;  // link address
        end else begin
            result = '0;
        end
    end

    assign ex_out = '{valid: in_valid, result: result, do_jump: do_jump, j_addr: j_addr};

endmodule

// ==== exe_mem_reg.sv ====
`timescale 1ns/10ps

module exe_mem_reg (
    input  logic                  sys_clk,
    input  logic                  arst_n,
    input  mips_exe_pkg::ex_mem_t ex_in,
    input  logic                  in_valid,
    input  logic                  stall,
    output mips_exe_pkg::ex_mem_t ex_mem
);
    import mips_exe_pkg::*;

    logic  accept;
    logic  valid_q;
    logic  do_jump_q;
    word_t result_q;
    word_t j_addr_q;

    assign accept = in_valid && !stall;

    // bubble unless an instruction completes this cycle
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q   <= 1'b0;
            do_jump_q <= 1'b0;
        end else begin
            valid_q   <= accept && ex_in.valid;
            do_jump_q <= accept && ex_in.do_jump;
        end
    end

    always_ff @(posedge sys_clk) begin
        result_q <= ex_in.result;
        j_addr_q <= ex_in.j_addr;  // only looked at with do_jump
    end

    assign ex_mem = '{valid: valid_q, result: result_q, do_jump: do_jump_q, j_addr: j_addr_q};

endmodule

// ==== exe_stage.sv ====
`timescale 1ns/10ps

module exe_stage #(
    parameter int MUL_BITS_PER_CYCLE = 2  // 1, 2 or 4
) (
    input  logic                  sys_clk,
    input  logic                  arst_n,
    input  mips_exe_pkg::id_ex_t  id_ex,
    input  logic                  in_valid,
    output logic                  stall,
    output mips_exe_pkg::ex_mem_t ex_mem
);
    import mips_exe_pkg::*;

    ex_mem_t ex_comb;  // unregistered execute result

    execute #(
        .MUL_BITS_PER_CYCLE (MUL_BITS_PER_CYCLE)
    ) u_execute (
        .sys_clk  (sys_clk),
        .arst_n   (arst_n),
        .id_ex    (id_ex),
        .in_valid (in_valid),
        .ex_out   (ex_comb),
        .stall    (stall)
    );

    exe_mem_reg u_exe_mem_reg (
        .sys_clk  (sys_clk),
        .arst_n   (arst_n),
        .ex_in    (ex_comb),
        .in_valid (in_valid),
        .stall    (stall),
        .ex_mem   (ex_mem)
    );

endmodule

// ==== exe_stage_assert.sv ====
`timescale 1ns/10ps

module exe_stage_assert (
    input logic                 sys_clk,
    input logic                 arst_n,
    input logic                 in_valid,
    input mips_exe_pkg::id_ex_t id_ex,
    input logic                 stall,
    input logic                 mul_done,
    input logic                 ex_mem_valid
);
    int fail_count = 0;  // failed assertions so far

    // upstream keeps the stalled instruction presented
    stall_needs_valid: assert property (
        @(posedge sys_clk) disable iff (!arst_n) stall |=> in_valid && $stable(id_ex)
    ) else begin
        $error("in_valid or id_ex changed while the stage was stalled");
        fail_count = fail_count + 1;
    end

    done_one_cycle: assert property (
        @(posedge sys_clk) disable iff (!arst_n) mul_done |=> !mul_done
    ) else begin
        $error("multiplier done held for more than one cycle");
        fail_count = fail_count + 1;
    end

    // a stalled cycle writes a bubble
    bubble_after_stall: assert property (
        @(posedge sys_clk) disable iff (!arst_n) stall |=> !ex_mem_valid
    ) else begin
        $error("ex_mem.valid high right after a stall cycle");
        fail_count = fail_count + 1;
    end

endmodule

bind exe_stage exe_stage_assert u_exe_stage_assert (
    .sys_clk      (sys_clk),
    .arst_n       (arst_n),
    .in_valid     (in_valid),
    .id_ex        (id_ex),
    .stall        (stall),
    .mul_done     (u_execute.mul_done),
    .ex_mem_valid (ex_mem.valid)
);

// ==== tb_exe_stage.sv ====
`timescale 1ns/10ps

module tb_exe_stage;
    import mips_exe_pkg::*;

    localparam int MUL_BPC = 2;

    // opcodes and functions the package leaves out
    localparam opcode_t OP_ADDI  = 6'b001000;
    localparam opcode_t OP_ADDIU = 6'b001001;
    localparam opcode_t OP_ANDI  = 6'b001100;
    localparam opcode_t OP_ORI   = 6'b001101;
    localparam opcode_t OP_XORI  = 6'b001110;
    localparam opcode_t OP_LW    = 6'b100011;
    localparam func_t   FN_ADD   = 6'b100000;
    localparam func_t   FN_ADDU  = 6'b100001;
    localparam func_t   FN_SUB   = 6'b100010;
    localparam func_t   FN_SUBU  = 6'b100011;
    localparam func_t   FN_AND   = 6'b100100;
    localparam func_t   FN_OR    = 6'b100101;
    localparam func_t   FN_XOR   = 6'b100110;
    localparam func_t   FN_NOR   = 6'b100111;

    logic    sys_clk;
    logic    arst_n;
    id_ex_t  id_ex;
    logic    in_valid;
    logic    stall;
    ex_mem_t ex_mem;

    id_ex_t  stim_q[$];
    ex_mem_t exp_q[$];
    integer  seed;
    int      stall_cycles;
    int      watchdog_cycles;

    exe_stage #(
        .MUL_BITS_PER_CYCLE (MUL_BPC)
    ) u_exe_stage (
        .sys_clk  (sys_clk),
        .arst_n   (arst_n),
        .id_ex    (id_ex),
        .in_valid (in_valid),
        .stall    (stall),
        .ex_mem   (ex_mem)
    );

    always #2 sys_clk = ~sys_clk;

    task automatic report_failure(input string what);
        $display("error at %0t ns: %s", $time, what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("mismatch at %0t ns: %s expected 0x%08h got 0x%08h", $time, name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch at %0t ns: %s expected %b got %b", $time, name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at the first error");
        end
    endtask

    function automatic logic is_mul_op(input id_ex_t d);
        return d.r_op && (d.func == FN_MUL || d.func == FN_MULU);
    endfunction

    // expected execute result straight from the instruction semantics
    function automatic ex_mem_t ref_model(input id_ex_t d);
        ex_mem_t            e;
        word_t              b;
        shamt_t             sh;
        logic [63:0]        wide;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic               taken;
        e = '0;
        e.valid = 1'b1;
        b = d.alu_src ? d.immd : d.reg2;
        sh = (d.func == FN_SLLV || d.func == FN_SRLV || d.func == FN_SRAV) ? d.reg1[4:0]
                                                                           : d.ins_shamt;
        if (d.alu_bypass) begin
            e.result = d.bypass_immd;
        end else if (d.is_load_store) begin
            e.result = d.reg1 + d.immd;  // effective address
        end else if (d.r_op) begin
            case (d.func)
                FN_ADD, FN_ADDU: e.result = d.reg1 + b;
                FN_SUB, FN_SUBU: e.result = d.reg1 - b;
                FN_AND:          e.result = d.reg1 & b;
                FN_OR:           e.result = d.reg1 | b;
                FN_XOR:          e.result = d.reg1 ^ b;
                FN_NOR:          e.result = ~(d.reg1 | b);
                FN_SLT:          e.result = {31'b0, ($signed(d.reg1) < $signed(b))};
                FN_SLTU:         e.result = {31'b0, (d.reg1 < b)};
                FN_SLL, FN_SLLV: e.result = d.reg2 << sh;
                FN_SRL, FN_SRLV, FN_SRA, FN_SRAV: begin
                    wide = {32'b0, d.reg2};
                    if (d.func == FN_SRA || d.func == FN_SRAV) begin
                        wide[63:32] = {32{d.reg2[31]}};  // sign fill
                    end
                    wide = wide >> sh;
                    e.result = wide[31:0];
                end
                FN_MUL, FN_MULU: begin
                    if (d.func == FN_MUL) begin
                        sa = {{32{d.reg1[31]}}, d.reg1};
                        sb = {{32{d.reg2[31]}}, d.reg2};
                    end else begin
                        sa = {32'b0, d.reg1};
                        sb = {32'b0, d.reg2};
                    end
                    wide = sa * sb;
                    e.result = (d.ins_shamt == SHAMT_MUL_LO) ? wide[31:0] : wide[63:32];
                end
                default: e.result = '0;
            endcase
        end else begin
            case (d.opcode)
                OP_ADDI, OP_ADDIU: e.result = d.reg1 + d.immd;
                OP_SLTI:  e.result = {31'b0, ($signed(d.reg1) < $signed(d.immd))};
                OP_SLTIU: e.result = {31'b0, (d.reg1 < d.immd)};
                OP_ANDI:  e.result = d.reg1 & d.immd;
                OP_ORI:   e.result = d.reg1 | d.immd;
                OP_XORI:  e.result = d.reg1 ^ d.immd;
                OP_LUI:   e.result = {d.immd[15:0], 16'h0000};
                OP_JAL:   e.result = d.next_pc + 32'd4;  // link
                default:  e.result = '0;
            endcase
        end
        case (d.opcode)
            OP_BEQ:  taken = d.reg1 == d.reg2;
            OP_BNE:  taken = d.reg1 != d.reg2;
            OP_BLEZ: taken = $signed(d.reg1) <= 0;
            OP_BGTZ: taken = $signed(d.reg1) > 0;
            default: taken = 1'b0;
        endcase
        if (d.is_jump) begin
            e.do_jump = 1'b1;
            e.j_addr  = d.is_jr ? d.reg1 : {d.next_pc[31:28], d.ins_j_addr, 2'b00};
        end else if (d.is_branch && taken) begin
            e.do_jump = 1'b1;
            e.j_addr  = d.next_pc + (d.immd << 2);
        end
        return e;
    endfunction

    function automatic id_ex_t r_instr(input func_t fn, input word_t rs, input word_t rt,
                                       input shamt_t sh);
        id_ex_t d;
        d = '0;
        d.next_pc   = 32'h0040_0104;
        d.r_op      = 1'b1;
        d.func      = fn;
        d.reg1      = rs;
        d.reg2      = rt;
        d.ins_shamt = sh;
        return d;
    endfunction

    function automatic id_ex_t i_instr(input opcode_t op, input word_t rs, input word_t imm);
        id_ex_t d;
        d = '0;
        d.next_pc = 32'h0040_0200;
        d.opcode  = op;
        d.reg1    = rs;
        d.reg2    = 32'hdead_beef;  // must not leak into op2
        d.immd    = imm;
        d.alu_src = 1'b1;
        return d;
    endfunction

    function automatic id_ex_t branch_instr(input opcode_t op, input word_t rs, input word_t rt,
                                            input word_t imm);
        id_ex_t d;
        d = i_instr(op, rs, imm);
        d.alu_src   = 1'b0;
        d.reg2      = rt;
        d.is_branch = 1'b1;
        return d;
    endfunction

    function automatic id_ex_t jump_instr(input opcode_t op, input jidx_t idx);
        id_ex_t d;
        d = '0;
        d.next_pc    = 32'h9040_0300;
        d.opcode     = op;
        d.ins_j_addr = idx;
        d.is_jump    = 1'b1;
        d.is_jal     = op == OP_JAL;
        return d;
    endfunction

    task automatic add_entry(input id_ex_t d);
        stim_q.push_back(d);
        exp_q.push_back(ref_model(d));
    endtask

    task automatic build_table();
        id_ex_t d;
        word_t  a;
        word_t  b;
        add_entry(r_instr(FN_ADD, 32'h7fff_ffff, 32'h0000_0001, 5'd0));  // wraps, no trap
        add_entry(r_instr(FN_ADDU, 32'hffff_fff0, 32'h0000_0020, 5'd0));
        add_entry(r_instr(FN_SUB, 32'h0000_0005, 32'h0000_0007, 5'd0));
        add_entry(r_instr(FN_SUBU, 32'h8000_0000, 32'h0000_0001, 5'd0));
        add_entry(r_instr(FN_AND, 32'hf0f0_ff00, 32'h0ff0_f0f0, 5'd0));
        add_entry(r_instr(FN_OR, 32'hf000_000f, 32'h0f00_00f0, 5'd0));
        add_entry(r_instr(FN_XOR, 32'haaaa_5555, 32'hffff_0000, 5'd0));
        add_entry(r_instr(FN_NOR, 32'h1234_0000, 32'h0000_5678, 5'd0));
        add_entry(i_instr(OP_ADDI, 32'h0000_0100, 32'hffff_ff00));
        add_entry(i_instr(OP_ADDIU, 32'h1000_0000, 32'h0000_7fff));
        add_entry(i_instr(OP_ANDI, 32'hffff_ffff, 32'h0000_a5a5));
        add_entry(i_instr(OP_ORI, 32'h1200_0000, 32'h0000_0034));
        add_entry(i_instr(OP_XORI, 32'h0000_ffff, 32'h0000_0ff0));
        add_entry(i_instr(OP_LUI, 32'h0, 32'h0000_beef));
        d = i_instr(OP_LW, 32'h1000_0040, 32'hffff_fffc);
        d.is_load_store = 1'b1;
        add_entry(d);
        d = i_instr(OP_ADDIU, 32'h1, 32'h1);
        d.alu_bypass  = 1'b1;
        d.bypass_immd = 32'h1234_5678;
        add_entry(d);
        // set-less-than, mixed signs and overflow edges
        add_entry(r_instr(FN_SLT, 32'hffff_ffff, 32'h0000_0001, 5'd0));
        add_entry(r_instr(FN_SLT, 32'h7fff_ffff, 32'h8000_0000, 5'd0));
        add_entry(r_instr(FN_SLT, 32'h8000_0000, 32'h0000_0001, 5'd0));
        add_entry(r_instr(FN_SLTU, 32'h0000_0001, 32'hffff_ffff, 5'd0));
        add_entry(r_instr(FN_SLTU, 32'hffff_ffff, 32'h0000_0001, 5'd0));
        add_entry(i_instr(OP_SLTI, 32'h8000_0000, 32'h0000_7fff));
        add_entry(i_instr(OP_SLTIU, 32'h0000_0010, 32'hffff_fff0));
        add_entry(i_instr(OP_SLTIU, 32'h0000_0000, 32'h0000_0000));
        add_entry(r_instr(FN_SLL, 32'h0, 32'h8000_0001, 5'd4));
        add_entry(r_instr(FN_SRL, 32'h0, 32'h8000_0010, 5'd4));
        add_entry(r_instr(FN_SRA, 32'h0, 32'h8000_0010, 5'd4));
        add_entry(r_instr(FN_SLLV, 32'hffff_ffe3, 32'h0000_00ff, 5'd0));
        add_entry(r_instr(FN_SRLV, 32'h0000_001f, 32'hf000_0000, 5'd0));
        add_entry(r_instr(FN_SRAV, 32'h0000_0008, 32'hf123_4567, 5'd9));
        add_entry(branch_instr(OP_BEQ, 32'h55, 32'h55, 32'hffff_fff0));
        add_entry(branch_instr(OP_BEQ, 32'h55, 32'h56, 32'h0000_0010));
        add_entry(branch_instr(OP_BNE, 32'h55, 32'h56, 32'h0000_0010));
        add_entry(branch_instr(OP_BNE, 32'h55, 32'h55, 32'h0000_0010));
        add_entry(branch_instr(OP_BLEZ, 32'h0, 32'h7, 32'h0000_0003));
        add_entry(branch_instr(OP_BLEZ, 32'h1, 32'h7, 32'h0000_0003));
        add_entry(branch_instr(OP_BGTZ, 32'h7fff_ffff, 32'h0, 32'h0000_0020));
        add_entry(branch_instr(OP_BGTZ, 32'h8000_0000, 32'h0, 32'h0000_0020));
        add_entry(jump_instr(OP_J, 26'h2ab_cdef));
        add_entry(jump_instr(OP_JAL, 26'h000_1234));
        d = r_instr(FN_JR, 32'h0040_8000, 32'h0, 5'd0);
        d.is_jump = 1'b1;
        d.is_jr   = 1'b1;
        add_entry(d);
        add_entry(r_instr(FN_MUL, 32'h8000_0000, 32'h8000_0000, SHAMT_MUL_HI));
        for (int k = 0; k < 8; k++) begin
            a = $random(seed);
            b = $random(seed);
            add_entry(r_instr(k[0] ? FN_MULU : FN_MUL, a, b,
                              k[1] ? SHAMT_MUL_HI : SHAMT_MUL_LO));
        end
    endtask

    initial begin
        sys_clk         = 1'b0;
        arst_n          = 1'b0;
        in_valid        = 1'b0;
        id_ex           = '0;
        seed            = 8;
        watchdog_cycles = 0;
        build_table();
        watchdog_cycles = stim_q.size() * 40 + 100;
        repeat (16) @(negedge sys_clk);
        arst_n = 1'b1;
        @(negedge sys_clk);
        check_bit("ex_mem.valid", 1'b0, ex_mem.valid);
        check_bit("ex_mem.do_jump", 1'b0, ex_mem.do_jump);
        check_bit("stall", 1'b0, stall);
        for (int i = 0; i < stim_q.size(); i++) begin
            id_ex        = stim_q[i];
            in_valid     = 1'b1;
            stall_cycles = 0;
            #1;  // mid low phase, inputs settled
            while (stall) begin
                if (stall_cycles > 0) begin
                    check_bit("ex_mem.valid", 1'b0, ex_mem.valid);
                end
                stall_cycles++;
                @(negedge sys_clk);
                #1;
            end
            if (stall_cycles != (is_mul_op(stim_q[i]) ? 32 / MUL_BPC + 1 : 0)) begin
                report_failure($sformatf("entry %0d stalled for %0d cycles", i, stall_cycles));
            end
            @(posedge sys_clk);
            @(negedge sys_clk);
            check_bit("ex_mem.valid", exp_q[i].valid, ex_mem.valid);
            check_word("ex_mem.result", exp_q[i].result, ex_mem.result);
            check_bit("ex_mem.do_jump", exp_q[i].do_jump, ex_mem.do_jump);
            check_word("ex_mem.j_addr", exp_q[i].j_addr, ex_mem.j_addr);
        end
        in_valid = 1'b0;
        repeat (2) @(negedge sys_clk);
        if (u_exe_stage.u_exe_stage_assert.fail_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            report_failure("a bound assertion failed during the run");
        end
    end

    // watchdog sized from the table
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge sys_clk);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== exe_stage.f ====
mips_exe_pkg.sv
alu.sv
branch_unit.sv
multiplier.sv
execute.sv
exe_mem_reg.sv
exe_stage.sv
exe_stage_assert.sv
tb_exe_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_exe_stage -f exe_stage.f
./obj_dir/Vtb_exe_stage +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
